// File: filelist.f
+incdir+verilog
verilog/pcie_req_pkg.sv
verilog/pcie_ctrl_pkg.sv
verilog/cpl_stream_if.sv
verilog/tx_commit_gen.sv
verilog/commit_fifo.sv
verilog/rxreq_merge.sv
verilog/tag_mode_tracker.sv
verilog/pcie_edge_top.sv
testbench/pcie_edge_properties.sv
testbench/pcie_edge_checker.sv
testbench/tb_pcie_edge.sv

// File: testbench/pcie_edge_checker.sv
// Port checker that predicts the TX and RXREQ streams and counts mismatches
`timescale 1ns/10ps
`default_nettype none

module pcie_edge_checker
   import pcie_req_pkg::*;
   import pcie_ctrl_pkg::*;
(
   input  wire            fim_clk,
   input  wire            csr_rst_n,
   input  wire            tx_valid,
   input  wire            tx_ready,
   input  wire t_pcie_req tx_req,
   input  wire            ss_tx_valid,
   input  wire            ss_tx_ready,
   input  wire t_pcie_req ss_tx_req,
   input  wire            host_rxreq_valid,
   input  wire            host_rxreq_ready,
   input  wire t_pcie_req host_rxreq,
   input  wire            rxreq_valid,
   input  wire            rxreq_ready,
   input  wire t_pcie_req rxreq,
   input  wire t_tag_mode tag_mode,
   output int             errors
);

   t_pcie_req exp_ss[$];
   t_pcie_req exp_cpl[$];
   t_pcie_req exp_host[$];

   initial begin
      errors = 0;
   end

   task automatic report_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("MISMATCH @ %0t: %s got %h expected %h", $time, what, got, exp);
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR @ %0t: %s", $time, msg);
   endtask

   function automatic int pending();
      return exp_ss.size() + exp_cpl.size() + exp_host.size();
   endfunction

   task automatic expect_tag_mode(input t_tag_mode exp, input string what);
      if (tag_mode !== exp) begin
         report_mismatch(what, 64'(tag_mode), 64'(exp));
      end
   endtask

   task automatic compare_count(input string what, input int got, input int exp);
      if (got != exp) begin
         report_mismatch(what, 64'(got), 64'(exp));
      end
   endtask

   task automatic expect_drained();
      if (pending() != 0) begin
         report_error($sformatf("%0d expected items never appeared", pending()));
      end
   endtask

   // --------------------
   // Stream watch
   // --------------------

   // Inputs move 2 ns after the rising edge, so the falling edge sees the next handshake
   always @(negedge fim_clk) begin
      t_pcie_req want;
      if (csr_rst_n) begin
         if (tx_valid && tx_ready) begin
            exp_ss.push_back(tx_req);
            if (tx_req.op == OP_MWR) begin
               want.op   = OP_CPL;
               want.tag  = tx_req.tag;
               want.func = tx_req.func;
               want.len  = '0;
               exp_cpl.push_back(want);
            end
         end
         if (host_rxreq_valid && host_rxreq_ready) begin
            exp_host.push_back(host_rxreq);
         end
         if (ss_tx_valid && ss_tx_ready) begin
            if (exp_ss.size() == 0) begin
               report_error("ss_tx sent a request that was never accepted on tx");
            end else begin
               want = exp_ss.pop_front();
               if (ss_tx_req !== want) begin
                  report_mismatch("ss_tx_req", ss_tx_req, want);
               end
            end
         end
         if (rxreq_valid && rxreq_ready) begin
            if (rxreq.op == OP_CPL) begin
               if (exp_cpl.size() == 0) begin
                  report_error("completion on rxreq with no write outstanding");
               end else begin
                  want = exp_cpl.pop_front();
                  if (rxreq !== want) begin
                     report_mismatch("rxreq commit", rxreq, want);
                  end
               end
            end else if (exp_host.size() == 0) begin
               report_error("host item on rxreq that the host never sent");
            end else begin
               want = exp_host.pop_front();
               if (rxreq !== want) begin
                  report_mismatch("rxreq host item", rxreq, want);
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: testbench/pcie_edge_properties.sv
// Concurrent port rules for the PCIe request edge top level
`timescale 1ns/10ps
`default_nettype none

module pcie_edge_properties
   import pcie_req_pkg::*;
   import pcie_ctrl_pkg::*;
(
   input wire            fim_clk,
   input wire            csr_rst_n,
   input wire            ss_tx_valid,
   input wire            ss_tx_ready,
   input wire t_pcie_req ss_tx_req,
   input wire            rxreq_valid,
   input wire            rxreq_ready,
   input wire t_pcie_req rxreq,
   input wire t_tag_mode tag_mode
);

   int fail_count = 0;

   a_tag_onehot : assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      $onehot(tag_mode))
      else begin
         fail_count++;
         $error("tag_mode is not one-hot");
      end

   // Held items keep their valid and payload until taken
   a_rxreq_hold : assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      rxreq_valid && !rxreq_ready |=> rxreq_valid && $stable(rxreq))
      else begin
         fail_count++;
         $error("rxreq changed or dropped under back-pressure");
      end

   a_ss_tx_hold : assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      ss_tx_valid && !ss_tx_ready |=> ss_tx_valid && $stable(ss_tx_req))
      else begin
         fail_count++;
         $error("ss_tx changed or dropped under back-pressure");
      end

   a_reset_idle : assert property (@(posedge fim_clk)
      $rose(csr_rst_n) |-> !rxreq_valid && !ss_tx_valid)
      else begin
         fail_count++;
         $error("stream valid high in the first cycle after reset");
      end

   // Commits never carry a payload length
   a_cpl_len : assert property (@(posedge fim_clk) disable iff (!csr_rst_n)
      rxreq_valid && rxreq.op == OP_CPL |-> rxreq.len == '0)
      else begin
         fail_count++;
         $error("completion on rxreq with nonzero length");
      end

endmodule

`default_nettype wire

// File: testbench/tb_pcie_edge.sv
// Table driven testbench for the PCIe request edge with port checker and bound rules
`timescale 1ns/10ps
`default_nettype none

`include "pcie_edge_params.svh"

module tb_pcie_edge
   import pcie_req_pkg::*;
   import pcie_ctrl_pkg::*;
();

   typedef enum {STEP_TX, STEP_HOST, STEP_SHDW, STEP_BP} t_step_kind;
   typedef enum {BP_OFF, BP_RANDOM, BP_HOLD} t_bp_mode;

   typedef struct {
      t_step_kind              kind;
      t_pcie_req               req;
      logic [`CTRL_SHDW_W-1:0] shdw;
      t_tag_mode               exp_mode;
      t_bp_mode                bp;
      bit                      stall;   // write must wait on a full commit queue
   } t_step;

   logic                    fim_clk = 1'b0;
   logic                    csr_rst_n;
   logic                    tx_valid;
   logic                    tx_ready;
   t_pcie_req               tx_req;
   logic                    ss_tx_valid;
   logic                    ss_tx_ready;
   t_pcie_req               ss_tx_req;
   logic                    host_rxreq_valid;
   logic                    host_rxreq_ready;
   t_pcie_req               host_rxreq;
   logic                    rxreq_valid;
   logic                    rxreq_ready;
   t_pcie_req               rxreq;
   logic                    ctrl_shdw_valid;
   logic [`CTRL_SHDW_W-1:0] ctrl_shdw_data;
   t_tag_mode               tag_mode;

   t_step steps[$];
   int    n_steps = 0;
   int    n_fail = 0;
   int    err_count;
   int    errs_before;
   int    seed_ret;
   bit    bp_on = 1'b0;
   bit    hold_on = 1'b0;

   always #10 fim_clk = ~fim_clk;

   pcie_edge_top dut_i (.*);

   pcie_edge_checker chk_i (.*, .errors(err_count));

   bind pcie_edge_top pcie_edge_properties props_i (.*);

   // Ready pattern, updated 1 ns after the edge from flags set in the previous cycle
   always @(posedge fim_clk) begin
      #1;
      ss_tx_ready = bp_on ? 1'($urandom % 2) : 1'b1;
      rxreq_ready = hold_on ? 1'b0 : (bp_on ? 1'($urandom % 2) : 1'b1);
   end

   function automatic int total_errors();
      return err_count + dut_i.props_i.fail_count;
   endfunction

   function automatic t_pcie_req make_req(t_req_op op, int tag, int pf, int vf, bit vfa,
                                          int len);
      t_pcie_req r;
      r.op             = op;
      r.tag            = `PCIE_TAG_W'(tag);
      r.func.pf        = `PCIE_PF_W'(pf);
      r.func.vf        = `PCIE_VF_W'(vf);
      r.func.vf_active = vfa;
      r.len            = `PCIE_LEN_W'(len);
      return r;
   endfunction

   // Shadow word with random filler in the bits the decoder must ignore
   function automatic logic [`CTRL_SHDW_W-1:0] shadow_word(int pf, bit vfa, bit ext, bit t10);
      logic [`CTRL_SHDW_W-1:0] w;
      w       = `CTRL_SHDW_W'({$urandom, $urandom});
      w[2:0]  = 3'(pf);
      w[13:3] = 11'h2a5;
      w[14]   = vfa;
      w[29]   = ext;
      w[30]   = t10;
      return w;
   endfunction

   task automatic add_step(t_step_kind k, t_pcie_req r, logic [`CTRL_SHDW_W-1:0] w,
                           t_tag_mode m, t_bp_mode b, bit st);
      t_step s;
      s.kind     = k;
      s.req      = r;
      s.shdw     = w;
      s.exp_mode = m;
      s.bp       = b;
      s.stall    = st;
      steps.push_back(s);
   endtask

   // --------------------
   // Stimulus table
   // --------------------
   task automatic build_table();
      t_pcie_req nr;
      nr = '0;
      add_step(STEP_SHDW, nr, shadow_word(0, 0, 1, 0), TAG_8BIT, BP_OFF, 0);
      add_step(STEP_SHDW, nr, shadow_word(0, 0, 1, 1), TAG_10BIT, BP_OFF, 0);
      // Other PFs and VFs leave the mode alone
      add_step(STEP_SHDW, nr, shadow_word(2, 0, 0, 0), TAG_10BIT, BP_OFF, 0);
      add_step(STEP_SHDW, nr, shadow_word(0, 1, 1, 0), TAG_10BIT, BP_OFF, 0);
      add_step(STEP_SHDW, nr, shadow_word(0, 0, 0, 1), TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MRD, 1, 0, 0, 0, 16), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MWR, 2, 1, 0, 0, 4), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_INTR, 3, 0, 0, 0, 0), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_HOST, make_req(OP_MRD, 64, 0, 0, 0, 1), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MWR, 4, 0, 9, 1, 2), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_HOST, make_req(OP_MWR, 65, 0, 0, 0, 8), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_BP, nr, '0, TAG_5BIT, BP_RANDOM, 0);
      add_step(STEP_TX, make_req(OP_MWR, 5, 2, 0, 0, 1), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_HOST, make_req(OP_MRD, 66, 0, 0, 0, 2), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MWR, 6, 0, 3, 1, 7), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MRD, 7, 0, 0, 0, 3), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_HOST, make_req(OP_MRD, 67, 0, 0, 0, 5), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MWR, 8, 4, 0, 0, 9), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_BP, nr, '0, TAG_5BIT, BP_OFF, 0);
      // Fill the output register and the queue, then one more write must stall
      add_step(STEP_BP, nr, '0, TAG_5BIT, BP_HOLD, 0);
      for (int k = 0; k < `COMMIT_FIFO_DEPTH + 1; k++) begin
         add_step(STEP_TX, make_req(OP_MWR, 32 + k, k, 0, 0, 4), '0, TAG_5BIT, BP_OFF, 0);
      end
      add_step(STEP_TX, make_req(OP_MRD, 40, 0, 0, 0, 8), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_INTR, 41, 0, 0, 0, 0), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MWR, 42, 3, 7, 1, 1), '0, TAG_5BIT, BP_OFF, 1);
      add_step(STEP_HOST, make_req(OP_MRD, 68, 0, 0, 0, 4), '0, TAG_5BIT, BP_OFF, 0);
      add_step(STEP_TX, make_req(OP_MWR, 43, 5, 0, 0, 2), '0, TAG_5BIT, BP_OFF, 0);
   endtask

   // --------------------
   // Drivers, each starts and ends 2 ns after a rising edge
   // --------------------
   task automatic send_tx(input t_pcie_req r, input bit st);
      int stalled;
      tx_valid = 1'b1;
      tx_req   = r;
      if (st) begin
         stalled = 0;
         repeat (6) begin
            @(negedge fim_clk);
            if (!tx_ready) begin
               stalled++;
            end
         end
         chk_i.compare_count("stalled write cycles", stalled, 6);
         @(posedge fim_clk);
         #2;
         hold_on = 1'b0;
      end
      @(negedge fim_clk);
      while (!tx_ready) begin
         @(negedge fim_clk);
      end
      @(posedge fim_clk);
      #2;
      tx_valid = 1'b0;
   endtask

   task automatic send_host(input t_pcie_req r);
      host_rxreq_valid = 1'b1;
      host_rxreq       = r;
      @(negedge fim_clk);
      while (!host_rxreq_ready) begin
         @(negedge fim_clk);
      end
      @(posedge fim_clk);
      #2;
      host_rxreq_valid = 1'b0;
   endtask

   // Word sampled on the next edge, mode settles one edge later
   task automatic send_shdw(input logic [`CTRL_SHDW_W-1:0] w, input t_tag_mode m);
      ctrl_shdw_valid = 1'b1;
      ctrl_shdw_data  = w;
      @(posedge fim_clk);
      #2;
      ctrl_shdw_valid = 1'b0;
      @(posedge fim_clk);
      #2;
      chk_i.expect_tag_mode(m, "tag_mode after shadow word");
   endtask

   task automatic set_bp(input t_bp_mode b);
      if (b == BP_HOLD) begin
         // Earlier commits drain so the hold starts from an empty queue
         while (chk_i.pending() != 0) begin
            @(negedge fim_clk);
         end
         @(posedge fim_clk);
         #2;
      end
      bp_on   = (b == BP_RANDOM);
      hold_on = (b == BP_HOLD);
      @(posedge fim_clk);
      #2;
   endtask

   // Watchdog sized from the table length
   initial begin
      wait (n_steps != 0);
      #(n_steps * 40 * 20);
      $display("Timeout: the run did not finish within %0d cycles", n_steps * 40);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      seed_ret         = $urandom(32'h5444);
      csr_rst_n        = 1'b0;
      tx_valid         = 1'b0;
      tx_req           = '0;
      ss_tx_ready      = 1'b1;
      host_rxreq_valid = 1'b0;
      host_rxreq       = '0;
      rxreq_ready      = 1'b1;
      ctrl_shdw_valid  = 1'b0;
      ctrl_shdw_data   = '0;
      build_table();
      n_steps = steps.size();
      repeat (2) begin
         @(posedge fim_clk);
      end
      #2;
      csr_rst_n = 1'b1;
      chk_i.expect_tag_mode(TAG_5BIT, "tag_mode after reset");
      n_fail += (total_errors() != 0);
      $display("step reset: %s", (total_errors() == 0) ? "ok" : "fail");
      foreach (steps[i]) begin
         errs_before = total_errors();
         case (steps[i].kind)
            STEP_TX:   send_tx(steps[i].req, steps[i].stall);
            STEP_HOST: send_host(steps[i].req);
            STEP_SHDW: send_shdw(steps[i].shdw, steps[i].exp_mode);
            default:   set_bp(steps[i].bp);
         endcase
         n_fail += (total_errors() != errs_before);
         $display("step %0d %s: %s", i, steps[i].kind.name(),
                  (total_errors() == errs_before) ? "ok" : "fail");
      end
      // Remaining commits and host items must all come out
      errs_before = total_errors();
      for (int c = 0; c < 100 && chk_i.pending() != 0; c++) begin
         @(negedge fim_clk);
      end
      chk_i.expect_drained();
      n_fail += (total_errors() != errs_before);
      $display("step drain: %s", (total_errors() == errs_before) ? "ok" : "fail");
      $display("tests %0d, failed %0d, checker errors %0d, assertion failures %0d",
               n_steps + 2, n_fail, err_count, dut_i.props_i.fail_count);
      if (n_fail == 0 && total_errors() == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/commit_fifo.sv
// Circular queue holding write commit records until the RXREQ merger takes them
`timescale 1ns/10ps
`default_nettype none

`include "pcie_edge_params.svh"

module commit_fifo
   import pcie_req_pkg::*;
#(
   parameter int DEPTH = `COMMIT_FIFO_DEPTH
)(
   input  wire          fim_clk,
   input  wire          csr_rst_n,
   cpl_stream_if.sink   push,
   cpl_stream_if.source pop
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [`PCIE_TAG_W-1:0] tag_mem [DEPTH];
   t_func_id               func_mem [DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       count;
   logic                   do_push;
   logic                   do_pop;

   // Pointer step with wrap at DEPTH
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   // Full shows up only as push.ready low
   assign push.ready = (count != CNT_W'(DEPTH));
   assign do_push    = push.valid && push.ready;

   // Head entry is read straight from storage
   assign pop.valid = (count != '0);
   assign pop.tag   = tag_mem[rd_ptr];
   assign pop.func  = func_mem[rd_ptr];
   assign do_pop    = pop.valid && pop.ready;

   always_ff @(posedge fim_clk) begin
      if (do_push) begin
         tag_mem[wr_ptr]  <= push.tag;
         func_mem[wr_ptr] <= push.func;
      end
   end

   // --------------------
   // Pointers and occupancy
   // --------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Push and pop together leave the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/cpl_stream_if.sv
// Valid/ready stream carrying write commit records between edge blocks
`timescale 1ns/10ps
`default_nettype none

`include "pcie_edge_params.svh"

interface cpl_stream_if
   import pcie_req_pkg::*;
();

   logic                   valid;
   logic                   ready;
   logic [`PCIE_TAG_W-1:0] tag;
   t_func_id               func;   // function that issued the write

   modport source (
      output valid, tag, func,
      input  ready
   );

   modport sink (
      input  valid, tag, func,
      output ready
   );

endinterface

`default_nettype wire

// File: verilog/pcie_ctrl_pkg.sv
// Control-shadow word fields and one-hot tag mode encoding
`default_nettype none

`include "pcie_edge_params.svh"

package pcie_ctrl_pkg;

   // Bit positions inside the shadow word
   localparam int SHDW_PF_LSB        = 0;
   localparam int SHDW_VF_LSB        = 3;
   localparam int SHDW_VF_ACTIVE_BIT = 14;
   localparam int SHDW_EXT_TAG_BIT   = 29;
   localparam int SHDW_TAG10_BIT     = 30;

   // Only this PF owns the tag mode
   localparam logic [`PCIE_PF_W-1:0] TAG_OWNER_PF = '0;

   typedef struct packed {
      logic [`PCIE_PF_W-1:0] pf_num;
      logic [`PCIE_VF_W-1:0] vf_num;
      logic                  vf_active;
      logic                  extended_tag;
      logic                  tag_enable_10bit;
   } t_ctrl_shdw;

   // One-hot, exactly one bit set at any time
   typedef enum logic [2:0] {
      TAG_5BIT  = 3'b001,
      TAG_8BIT  = 3'b010,
      TAG_10BIT = 3'b100
   } t_tag_mode;

   // Pull the used fields out of a raw shadow word
   function automatic t_ctrl_shdw decode_ctrl_shdw(input logic [`CTRL_SHDW_W-1:0] word);
      t_ctrl_shdw f;
      f.pf_num           = word[SHDW_PF_LSB +: `PCIE_PF_W];
      f.vf_num           = word[SHDW_VF_LSB +: `PCIE_VF_W];
      f.vf_active        = word[SHDW_VF_ACTIVE_BIT];
      f.extended_tag     = word[SHDW_EXT_TAG_BIT];
      f.tag_enable_10bit = word[SHDW_TAG10_BIT];
      return f;
   endfunction

endpackage

`default_nettype wire

// File: verilog/pcie_edge_params.svh
// Shared field widths and commit queue depth for the PCIe request edge
`ifndef PCIE_EDGE_PARAMS_SVH
`define PCIE_EDGE_PARAMS_SVH

// --------------------
// Request fields
// --------------------

// Request tag, sized for 10-bit tag mode
`define PCIE_TAG_W 10

// Physical function number
`define PCIE_PF_W 3

// Virtual function number
`define PCIE_VF_W 11

// Length in dwords
`define PCIE_LEN_W 10

// --------------------
// Shadow word and queueing
// --------------------

// Control-shadow word as delivered by the subsystem
`define CTRL_SHDW_W 40

// Commit records held between TX and RXREQ
`define COMMIT_FIFO_DEPTH 4

`endif

// File: verilog/pcie_edge_top.sv
// Top level of the PCIe request edge with write commits and tag mode tracking
`timescale 1ns/10ps
`default_nettype none

`include "pcie_edge_params.svh"

module pcie_edge_top
   import pcie_req_pkg::*;
   import pcie_ctrl_pkg::*;
(
   input  wire                    fim_clk,
   input  wire                    csr_rst_n,

   // Accelerator TX
   input  wire                    tx_valid,
   output logic                   tx_ready,
   input  wire t_pcie_req         tx_req,

   // Subsystem TX
   output logic                   ss_tx_valid,
   input  wire                    ss_tx_ready,
   output t_pcie_req              ss_tx_req,

   // Host RXREQ from the subsystem
   input  wire                    host_rxreq_valid,
   output logic                   host_rxreq_ready,
   input  wire t_pcie_req         host_rxreq,

   // Merged RXREQ toward the accelerator
   output logic                   rxreq_valid,
   input  wire                    rxreq_ready,
   output t_pcie_req              rxreq,

   // Control shadow
   input  wire                    ctrl_shdw_valid,
   input  wire [`CTRL_SHDW_W-1:0] ctrl_shdw_data,
   output t_tag_mode              tag_mode
);

   // Commit path, producer to queue and queue to merger
   cpl_stream_if cpl_push ();
   cpl_stream_if cpl_pop ();

   tx_commit_gen tx_commit_gen_i (
      .fim_clk     (fim_clk),
      .csr_rst_n   (csr_rst_n),
      .tx_valid    (tx_valid),
      .tx_ready    (tx_ready),
      .tx_req      (tx_req),
      .ss_tx_valid (ss_tx_valid),
      .ss_tx_ready (ss_tx_ready),
      .ss_tx_req   (ss_tx_req),
      .commit      (cpl_push)
   );

   commit_fifo #(
      .DEPTH (`COMMIT_FIFO_DEPTH)
   ) commit_fifo_i (
      .fim_clk   (fim_clk),
      .csr_rst_n (csr_rst_n),
      .push      (cpl_push),
      .pop       (cpl_pop)
   );

   rxreq_merge rxreq_merge_i (
      .fim_clk          (fim_clk),
      .csr_rst_n        (csr_rst_n),
      .host_rxreq_valid (host_rxreq_valid),
      .host_rxreq_ready (host_rxreq_ready),
      .host_rxreq       (host_rxreq),
      .commit           (cpl_pop),
      .rxreq_valid      (rxreq_valid),
      .rxreq_ready      (rxreq_ready),
      .rxreq            (rxreq)
   );

   tag_mode_tracker tag_mode_tracker_i (
      .fim_clk         (fim_clk),
      .csr_rst_n       (csr_rst_n),
      .ctrl_shdw_valid (ctrl_shdw_valid),
      .ctrl_shdw_data  (ctrl_shdw_data),
      .tag_mode        (tag_mode)
   );

endmodule

`default_nettype wire

// File: verilog/pcie_req_pkg.sv
// Request opcodes and single-beat request header types for the PCIe edge
`default_nettype none

`include "pcie_edge_params.svh"

package pcie_req_pkg;

   // --------------------
   // Opcodes
   // --------------------

   // OP_CPL is only produced internally, as a write commit
   typedef enum logic [1:0] {
      OP_MRD  = 2'b00,
      OP_MWR  = 2'b01,
      OP_INTR = 2'b10,
      OP_CPL  = 2'b11
   } t_req_op;

   // --------------------
   // Headers
   // --------------------

   // Requesting function, 15 bits
   typedef struct packed {
      logic [`PCIE_PF_W-1:0] pf;
      logic [`PCIE_VF_W-1:0] vf;
      logic                  vf_active;
   } t_func_id;

   // Single-beat request header, 37 bits
   typedef struct packed {
      t_req_op                op;
      logic [`PCIE_TAG_W-1:0] tag;
      t_func_id               func;
      logic [`PCIE_LEN_W-1:0] len;   // dwords, zero on commits
   } t_pcie_req;

endpackage

`default_nettype wire

// File: verilog/rxreq_merge.sv
// Round-robin merge of host RXREQ items and write commits into one registered stream
`timescale 1ns/10ps
`default_nettype none

module rxreq_merge
   import pcie_req_pkg::*;
(
   input  wire            fim_clk,
   input  wire            csr_rst_n,

   // Host requests from the subsystem
   input  wire            host_rxreq_valid,
   output logic           host_rxreq_ready,
   input  wire t_pcie_req host_rxreq,

   // Commit records from the queue
   cpl_stream_if.sink     commit,

   // Merged stream toward the accelerator
   output logic           rxreq_valid,
   input  wire            rxreq_ready,
   output t_pcie_req      rxreq
);

   typedef enum logic {
      CH_HOST   = 1'b0,
      CH_COMMIT = 1'b1
   } t_rr_ch;

   t_rr_ch    last_ch;
   t_pcie_req cpl_item;
   t_pcie_req out_req;
   logic      out_valid;
   logic      can_load;
   logic      grant_host;
   logic      grant_cpl;
   logic      load;

   // Completion without data built from a commit record
   always_comb begin
      cpl_item.op   = OP_CPL;
      cpl_item.tag  = commit.tag;
      cpl_item.func = commit.func;
      cpl_item.len  = '0;
   end

   // --------------------
   // Arbitration
   // --------------------

   // Last winner yields when both sides are pending
   assign grant_host = host_rxreq_valid && (!commit.valid || last_ch == CH_COMMIT);
   assign grant_cpl  = commit.valid && !grant_host;

   // Output register reloads on the edge it drains
   assign can_load = !out_valid || rxreq_ready;
   assign load     = can_load && (grant_host || grant_cpl);

   assign host_rxreq_ready = can_load && grant_host;
   assign commit.ready     = can_load && grant_cpl;

   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         out_valid <= 1'b0;
         last_ch   <= CH_COMMIT;
      end else begin
         if (load) begin
            out_valid <= 1'b1;
            last_ch   <= grant_host ? CH_HOST : CH_COMMIT;
         end else if (rxreq_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge fim_clk) begin
      if (load) begin
         out_req <= grant_host ? host_rxreq : cpl_item;
      end
   end

   assign rxreq_valid = out_valid;
   assign rxreq       = out_req;

endmodule

`default_nettype wire

// File: verilog/tag_mode_tracker.sv
// Tracks the PF0 request tag mode from control-shadow words
`timescale 1ns/10ps
`default_nettype none

`include "pcie_edge_params.svh"

module tag_mode_tracker
   import pcie_ctrl_pkg::*;
(
   input  wire                    fim_clk,
   input  wire                    csr_rst_n,
   input  wire                    ctrl_shdw_valid,
   input  wire [`CTRL_SHDW_W-1:0] ctrl_shdw_data,
   output t_tag_mode              tag_mode
);

   logic       shdw_valid_q;
   t_ctrl_shdw shdw_q;
   logic       mode_upd;
   t_tag_mode  mode_next;

   // --------------------
   // Shadow word capture
   // --------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         shdw_valid_q <= 1'b0;
      end else begin
         shdw_valid_q <= ctrl_shdw_valid;
      end
   end

   always_ff @(posedge fim_clk) begin
      shdw_q <= decode_ctrl_shdw(ctrl_shdw_data);
   end

   // Words for other PFs or for VFs are ignored
   assign mode_upd = shdw_valid_q && (shdw_q.pf_num == TAG_OWNER_PF) && !shdw_q.vf_active;

   always_comb begin
      if (shdw_q.extended_tag && shdw_q.tag_enable_10bit) begin
         mode_next = TAG_10BIT;
      end else if (shdw_q.extended_tag) begin
         mode_next = TAG_8BIT;
      end else begin
         // Not extended, legacy 5 bit tags
         mode_next = TAG_5BIT;
      end
   end

   // --------------------
   // Tag mode
   // --------------------
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         tag_mode <= TAG_5BIT;
      end else if (mode_upd) begin
         tag_mode <= mode_next;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tx_commit_gen.sv
// TX forwarder that emits one commit record for every write passed to the subsystem
`timescale 1ns/10ps
`default_nettype none

module tx_commit_gen
   import pcie_req_pkg::*;
(
   input  wire            fim_clk,
   input  wire            csr_rst_n,

   // From the accelerator
   input  wire            tx_valid,
   output logic           tx_ready,
   input  wire t_pcie_req tx_req,

   // Toward the subsystem
   output logic           ss_tx_valid,
   input  wire            ss_tx_ready,
   output t_pcie_req      ss_tx_req,

   // Commit records toward the queue
   cpl_stream_if.source   commit
);

   logic run_q;
   logic is_wr;
   logic cpl_room;

   // Hold traffic off until the first edge out of reset
   always_ff @(posedge fim_clk) begin
      if (!csr_rst_n) begin
         run_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
      end
   end

   assign is_wr = (tx_req.op == OP_MWR);

   // Writes wait for a free commit slot, reads and interrupts never do
   assign cpl_room = !is_wr || commit.ready;

   // --------------------
   // Forward path
   // --------------------
   assign ss_tx_valid = run_q && tx_valid && cpl_room;
   assign ss_tx_req   = tx_req;
   assign tx_ready    = run_q && ss_tx_ready && cpl_room;

   // Commit pushes on the same edge the write leaves
   assign commit.valid = run_q && tx_valid && is_wr && ss_tx_ready;
   assign commit.tag   = tx_req.tag;
   assign commit.func  = tx_req.func;

endmodule

`default_nettype wire
